//--- rtl/mem_sys_settings.svh
// memory system settings: address split, word width, memory depth and bank latency
`ifndef MEM_SYS_SETTINGS_SVH
`define MEM_SYS_SETTINGS_SVH

// byte address and data word
`define MS_ADDR_W         16
`define MS_DATA_W         16

// address split is tag | index | byte offset
`define MS_TAG_W          5
`define MS_INDEX_W        8
`define MS_OFFSET_W       3

// words in a line, also the bank count
`define MS_WORDS_PER_LINE 4

// main memory depth in words, and cycles from accepted read to data
`define MS_MEM_WORDS      32768
`define MS_MEM_LAT        2

`endif

//--- rtl/mem_sys_pkg.sv
// memory system package: controller state and memory operation types
`default_nettype none

package mem_sys_pkg;

   // controller states
   typedef enum logic [3:0] {
      // waiting for rd or wr
      idle      = 4'd0,
      // compare access on the cache
      comp      = 4'd1,
      // look at hit and valid from compare
      check     = 4'd2,
      // direct read of one victim word
      rd_victim = 4'd3,
      // victim word out to memory
      wb        = 4'd4,
      // bank reads for the line fill
      fill_req  = 4'd5,
      // waiting on the last returned words
      fill_wr   = 4'd6,
      done_hit  = 4'd7,
      done_miss = 4'd8,
      done_err  = 4'd9
   } ctrl_state_t;

   // memory operation on the bank port
   typedef enum logic [1:0] {
      none  = 2'd0,
      read  = 2'd1,
      write = 2'd2
   } mem_op_t;

endpackage

`default_nettype wire

//--- rtl/cache_if.sv
// cache array port: command from the controller, registered response from the array
`default_nettype none
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

interface cache_if;

   // command side
   logic                        enable;
   logic                        comp;
   logic                        write;
   logic [`MS_TAG_W-1:0]        tag_in;
   logic [`MS_INDEX_W-1:0]      index;
   // word within the line, byte offset without bit 0
   logic [`MS_OFFSET_W-2:0]     word;
   logic [`MS_DATA_W-1:0]       data_in;

   // response side, valid the cycle after enable
   logic                        hit;
   logic                        valid;
   logic                        dirty;
   logic [`MS_TAG_W-1:0]        tag_out;
   logic [`MS_DATA_W-1:0]       data_out;

   modport ctrl (
      output enable, comp, write, tag_in, index, word, data_in,
      input  hit, valid, dirty, tag_out, data_out
   );

   modport array (
      input  enable, comp, write, tag_in, index, word, data_in,
      output hit, valid, dirty, tag_out, data_out
   );

endinterface

`default_nettype wire

//--- rtl/mem_if.sv
// banked memory port: request from the controller, read return and stall from memory
`default_nettype none
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

interface mem_if;

   // request, bank picked by addr[2:1]
   mem_sys_pkg::mem_op_t        op;
   logic [`MS_ADDR_W-1:0]       addr;
   logic [`MS_DATA_W-1:0]       wdata;

   // read data, rvalid a fixed latency after acceptance
   logic [`MS_DATA_W-1:0]       rdata;
   logic                        rvalid;
   // addressed bank still busy
   logic                        stall;

   modport ctrl (
      output op, addr, wdata,
      input  rdata, rvalid, stall
   );

   modport mem (
      input  op, addr, wdata,
      output rdata, rvalid, stall
   );

endinterface

`default_nettype wire

//--- rtl/cache_ctrl.sv
// cache controller: FSM that sequences compare, victim writeback, line fill and completion
`default_nettype none
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module cache_ctrl (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire [`MS_ADDR_W-1:0]    addr,
   input  wire [`MS_DATA_W-1:0]    data_in,
   input  wire                     rd,
   input  wire                     wr,
   output logic [`MS_DATA_W-1:0]   data_out,
   output logic                    done,
   output logic                    stall,
   output logic                    cache_hit,
   output logic                    err,
   cache_if.ctrl                   cif,
   mem_if.ctrl                     mif
);

   localparam int WORD_W = `MS_OFFSET_W - 1;
   localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(`MS_WORDS_PER_LINE - 1);

   mem_sys_pkg::ctrl_state_t state, nxt_state;

   // set once a request has missed, so the final hit reports a miss
   logic                     miss_flag;
   // victim word during writeback, request count during fill
   logic [WORD_W-1:0]        word_cnt;
   // fill words received
   logic [WORD_W-1:0]        rcv_cnt;
   logic                     bad_req;
   logic                     line_dirty;
   logic                     fill_rx;
   logic [`MS_TAG_W-1:0]     req_tag;
   logic [`MS_INDEX_W-1:0]   req_index;
   logic [WORD_W-1:0]        req_word;

   // request address split
   assign req_tag   = addr[`MS_ADDR_W-1 -: `MS_TAG_W];
   assign req_index = addr[`MS_OFFSET_W +: `MS_INDEX_W];
   assign req_word  = addr[1 +: WORD_W];

   // odd address or both strobes
   assign bad_req    = addr[0] | (rd & wr);
   // victim needs writeback only if it holds live data
   assign line_dirty = cif.valid & cif.dirty;
   // fill data can return while requests are still going out
   assign fill_rx    = ((state == mem_sys_pkg::fill_req) | (state == mem_sys_pkg::fill_wr))
                       & mif.rvalid;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= mem_sys_pkg::idle;
         miss_flag <= 1'b0;
         word_cnt  <= '0;
         rcv_cnt   <= '0;
      end else begin
         state <= nxt_state;
         case (state)
            mem_sys_pkg::idle: begin
               miss_flag <= 1'b0;
               word_cnt  <= '0;
               rcv_cnt   <= '0;
            end
            mem_sys_pkg::check: begin
               if (!(cif.hit & cif.valid)) begin
                  miss_flag <= 1'b1;
                  word_cnt  <= '0;
               end
            end
            // wraps back to word 0 after the last victim word
            mem_sys_pkg::wb: begin
               if (!line_dirty) word_cnt <= '0;
               else if (!mif.stall) word_cnt <= word_cnt + 1'b1;
            end
            mem_sys_pkg::fill_req: begin
               if (!mif.stall) word_cnt <= word_cnt + 1'b1;
            end
            default: ;
         endcase
         if (fill_rx) rcv_cnt <= rcv_cnt + 1'b1;
      end
   end

   always_comb begin
      nxt_state   = state;
      // cache defaults follow the processor request
      cif.enable  = 1'b0;
      cif.comp    = 1'b0;
      cif.write   = 1'b0;
      cif.tag_in  = req_tag;
      cif.index   = req_index;
      cif.word    = req_word;
      cif.data_in = data_in;
      mif.op      = mem_sys_pkg::none;
      mif.addr    = addr;
      mif.wdata   = cif.data_out;
      // returned fill word goes straight into the line, also sets tag and valid
      if (fill_rx) begin
         cif.enable  = 1'b1;
         cif.write   = 1'b1;
         cif.word    = rcv_cnt;
         cif.data_in = mif.rdata;
      end
      case (state)
         mem_sys_pkg::idle: begin
            if (rd | wr) nxt_state = bad_req ? mem_sys_pkg::done_err : mem_sys_pkg::comp;
         end
         mem_sys_pkg::comp: begin
            cif.enable = 1'b1;
            cif.comp   = 1'b1;
            cif.write  = wr;
            nxt_state  = mem_sys_pkg::check;
         end
         mem_sys_pkg::check: begin
            if (cif.hit & cif.valid)
               nxt_state = miss_flag ? mem_sys_pkg::done_miss : mem_sys_pkg::done_hit;
            else
               nxt_state = mem_sys_pkg::rd_victim;
         end
         mem_sys_pkg::rd_victim: begin
            cif.enable = 1'b1;
            cif.word   = word_cnt;
            nxt_state  = mem_sys_pkg::wb;
         end
         // victim address rebuilt from the stored tag
         mem_sys_pkg::wb: begin
            if (!line_dirty) begin
               nxt_state = mem_sys_pkg::fill_req;
            end else begin
               mif.op   = mem_sys_pkg::write;
               mif.addr = {cif.tag_out, req_index, word_cnt, 1'b0};
               if (!mif.stall)
                  nxt_state = (word_cnt == LAST_WORD) ? mem_sys_pkg::fill_req
                                                      : mem_sys_pkg::rd_victim;
            end
         end
         mem_sys_pkg::fill_req: begin
            mif.op   = mem_sys_pkg::read;
            mif.addr = {req_tag, req_index, word_cnt, 1'b0};
            if (!mif.stall && word_cnt == LAST_WORD) nxt_state = mem_sys_pkg::fill_wr;
         end
         // retry as a compare once the line is complete
         mem_sys_pkg::fill_wr: begin
            if (fill_rx && rcv_cnt == LAST_WORD) nxt_state = mem_sys_pkg::comp;
         end
         default: nxt_state = mem_sys_pkg::idle;
      endcase
   end

   // processor side outputs
   assign done      = (state == mem_sys_pkg::done_hit) | (state == mem_sys_pkg::done_miss)
                      | (state == mem_sys_pkg::done_err);
   assign cache_hit = (state == mem_sys_pkg::done_hit);
   assign err       = (state == mem_sys_pkg::done_err);
   assign data_out  = cif.data_out;
   // stall from the first cycle a strobe is seen, dropped on done
   assign stall     = (state == mem_sys_pkg::idle) ? (rd | wr) : !done;

endmodule

`default_nettype wire

//--- rtl/cache_array.sv
// cache array: direct-mapped tag, valid, dirty and data storage with compare and direct access
`default_nettype none
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module cache_array (
   input  wire       clk,
   input  wire       arst_n,
   cache_if.array    cif
);

   localparam int LINES  = 1 << `MS_INDEX_W;
   localparam int WORD_W = `MS_OFFSET_W - 1;

   logic [`MS_TAG_W-1:0]          tag_mem  [LINES];
   // one flat array, word address is {index, word}
   logic [`MS_DATA_W-1:0]         data_mem [LINES * `MS_WORDS_PER_LINE];
   logic [LINES-1:0]              valid_bits;
   logic [LINES-1:0]              dirty_bits;
   logic [`MS_INDEX_W+WORD_W-1:0] word_addr;
   logic                          tag_match;
   logic                          line_hit;
   logic                          do_write;
   logic                          store_data;

   assign word_addr  = {cif.index, cif.word};
   assign tag_match  = (tag_mem[cif.index] == cif.tag_in);
   assign line_hit   = valid_bits[cif.index] & tag_match;
   assign do_write   = cif.enable & cif.write;
   // compare writes land only on a valid hit, direct writes always
   assign store_data = do_write & (!cif.comp | line_hit);

   // line state
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (do_write) begin
         if (cif.comp) begin
            if (line_hit) dirty_bits[cif.index] <= 1'b1;
         end else begin
            // fill word, line now clean and owned by tag_in
            valid_bits[cif.index] <= 1'b1;
            dirty_bits[cif.index] <= 1'b0;
         end
      end
   end

   // response flags, reported as they were before the access
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cif.hit   <= 1'b0;
         cif.valid <= 1'b0;
         cif.dirty <= 1'b0;
      end else if (cif.enable) begin
         cif.hit   <= tag_match;
         cif.valid <= valid_bits[cif.index];
         cif.dirty <= dirty_bits[cif.index];
      end
   end

   // storage and payload response
   always_ff @(posedge clk) begin
      if (cif.enable) begin
         cif.tag_out  <= tag_mem[cif.index];
         cif.data_out <= data_mem[word_addr];
      end
      if (store_data) data_mem[word_addr] <= cif.data_in;
      if (do_write && !cif.comp) tag_mem[cif.index] <= cif.tag_in;
   end

endmodule

`default_nettype wire

//--- rtl/banked_mem.sv
// banked main memory: four word-interleaved banks with fixed read latency and busy tracking
`default_nettype none
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module banked_mem (
   input  wire       clk,
   input  wire       arst_n,
   mem_if.mem        mif
);

   localparam int BANKS      = `MS_WORDS_PER_LINE;
   localparam int BANK_DEPTH = `MS_MEM_WORDS / BANKS;
   localparam int SEL_W      = `MS_OFFSET_W - 1;
   localparam int ROW_W      = `MS_ADDR_W - `MS_OFFSET_W;
   localparam int LAT        = `MS_MEM_LAT;
   localparam int CNT_W      = $clog2(LAT + 1);

   logic [`MS_DATA_W-1:0] bank_mem [BANKS][BANK_DEPTH];
   logic [CNT_W-1:0]      busy_cnt [BANKS];
   logic [BANKS-1:0]      busy;
   // return pipeline per bank, stage 0 loaded on acceptance
   logic [LAT-1:0]        pipe_vld [BANKS];
   logic [`MS_DATA_W-1:0] pipe_dat [BANKS][LAT];
   logic [BANKS-1:0]      rd_acc;
   logic [SEL_W-1:0]      sel;
   logic [ROW_W-1:0]      row;
   logic                  accept;

   // word-interleaved, addr[2:1] picks the bank
   assign sel    = mif.addr[1 +: SEL_W];
   assign row    = mif.addr[`MS_OFFSET_W +: ROW_W];
   assign mif.stall = busy[sel];
   assign accept = (mif.op != mem_sys_pkg::none) & !mif.stall;

   always_comb begin
      for (int b = 0; b < BANKS; b++) begin
         busy[b]   = (busy_cnt[b] != '0);
         rd_acc[b] = accept & (mif.op == mem_sys_pkg::read) & (sel == SEL_W'(b));
      end
   end

   // contents start at zero
   initial begin
      for (int b = 0; b < BANKS; b++)
         for (int r = 0; r < BANK_DEPTH; r++)
            bank_mem[b][r] = '0;
   end

   // bank arrays and return data
   always_ff @(posedge clk) begin
      if (accept && mif.op == mem_sys_pkg::write) bank_mem[sel][row] <= mif.wdata;
      for (int b = 0; b < BANKS; b++) begin
         if (rd_acc[b]) pipe_dat[b][0] <= bank_mem[b][row];
         for (int s = 1; s < LAT; s++)
            pipe_dat[b][s] <= pipe_dat[b][s-1];
      end
   end

   // busy from acceptance through the return cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < BANKS; b++) begin
            busy_cnt[b] <= '0;
            pipe_vld[b] <= '0;
         end
      end else begin
         for (int b = 0; b < BANKS; b++) begin
            if (rd_acc[b]) busy_cnt[b] <= CNT_W'(LAT);
            else if (busy[b]) busy_cnt[b] <= busy_cnt[b] - 1'b1;
            pipe_vld[b] <= (pipe_vld[b] << 1) | LAT'(rd_acc[b]);
         end
      end
   end

   // equal latency keeps returns one per cycle, so a plain merge is enough
   always_comb begin
      mif.rvalid = 1'b0;
      mif.rdata  = '0;
      for (int b = 0; b < BANKS; b++) begin
         if (pipe_vld[b][LAT-1]) begin
            mif.rvalid = 1'b1;
            mif.rdata  = pipe_dat[b][LAT-1];
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/mem_system.sv
// data memory system top: controller, direct-mapped cache array and banked main memory
`default_nettype none
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module mem_system (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire [`MS_ADDR_W-1:0]    addr,
   input  wire [`MS_DATA_W-1:0]    data_in,
   input  wire                     rd,
   input  wire                     wr,
   output wire [`MS_DATA_W-1:0]    data_out,
   output wire                     done,
   output wire                     stall,
   output wire                     cache_hit,
   output wire                     err
);

   // controller to cache array
   cache_if u_cache_if ();

   // controller to main memory
   mem_if u_mem_if ();

   // request sequencing and processor handshake
   cache_ctrl u_cache_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .addr       (addr),
      .data_in    (data_in),
      .rd         (rd),
      .wr         (wr),
      .data_out   (data_out),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (err),
      .cif        (u_cache_if.ctrl),
      .mif        (u_mem_if.ctrl)
   );

   // 256 lines of four words
   cache_array u_cache_array (
      .clk        (clk),
      .arst_n     (arst_n),
      .cif        (u_cache_if.array)
   );

   // four banks, reads overlap across banks
   banked_mem u_banked_mem (
      .clk        (clk),
      .arst_n     (arst_n),
      .mif        (u_mem_if.mem)
   );

endmodule

`default_nettype wire

//--- bench/mem_system_tb.sv
// memory system testbench driving directed and random requests against a shadow model
`default_nettype none
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module mem_system_tb;

   localparam int ADDR_W       = `MS_ADDR_W;
   localparam int DATA_W       = `MS_DATA_W;
   localparam int TAG_W        = `MS_TAG_W;
   localparam int INDEX_W      = `MS_INDEX_W;
   localparam int LINES        = 1 << INDEX_W;
   localparam int CLK_PERIOD   = 8;
   localparam int NUM_DIRECTED = 19;
   localparam int NUM_RANDOM   = 300;
   // sixty cycles per request, about three times a dirty miss
   localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 60;

   // one expected done response
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              chk_data;
      logic              err;
      logic              hit;
      logic [DATA_W-1:0] data;
   } expect_t;

   logic              clk;
   logic              arst_n;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [DATA_W-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   // shadow of what the processor should see
   logic [DATA_W-1:0] shadow_mem   [`MS_MEM_WORDS];
   logic [TAG_W-1:0]  shadow_tag   [LINES];
   logic              shadow_valid [LINES];

   expect_t exp_q [$];
   int checks;
   int data_errors;
   int flag_errors;
   int timing_errors;

   mem_system u_mem_system (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // expected response from the alignment rule, shadow tags and shadow memory
   function automatic expect_t predict(input logic do_rd, input logic do_wr,
                                       input logic [ADDR_W-1:0] a);
      expect_t            e;
      logic [TAG_W-1:0]   t;
      logic [INDEX_W-1:0] i;
      t          = a[ADDR_W-1 -: TAG_W];
      i          = a[`MS_OFFSET_W +: INDEX_W];
      e.addr     = a;
      e.err      = a[0] | (do_rd & do_wr);
      e.hit      = !e.err && shadow_valid[i] && (shadow_tag[i] == t);
      e.chk_data = !e.err && do_rd;
      e.data     = shadow_mem[a[ADDR_W-1:1]];
      return e;
   endfunction

   // line now owned by this tag and write data lands in the shadow
   function automatic void update_shadow(input logic do_wr, input logic [ADDR_W-1:0] a,
                                         input logic [DATA_W-1:0] d);
      logic [INDEX_W-1:0] i;
      i               = a[`MS_OFFSET_W +: INDEX_W];
      shadow_tag[i]   = a[ADDR_W-1 -: TAG_W];
      shadow_valid[i] = 1'b1;
      if (do_wr) shadow_mem[a[ADDR_W-1:1]] = d;
   endfunction

   // raise the strobes and hold them until done
   task automatic run_request(input logic do_rd, input logic do_wr,
                              input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      expect_t e;
      int      waited;
      e = predict(do_rd, do_wr, a);
      @(posedge clk);
      #1;
      addr    = a;
      data_in = d;
      rd      = do_rd;
      wr      = do_wr;
      exp_q.push_back(e);
      if (!e.err) update_shadow(do_wr, a, d);
      waited = 0;
      @(negedge clk);
      while (!done) begin
         assert (stall) else begin
            timing_errors++;
            $display("ERROR %0t ns: stall low while request to %h pending", $time, a);
         end
         waited++;
         @(negedge clk);
      end
      // fixed latency for hits and errors
      if (e.err) begin
         assert (waited == 1) else begin
            timing_errors++;
            $display("ERROR %0t ns: error done after %0d cycles, expected 1", $time, waited);
         end
      end else if (e.hit) begin
         assert (waited == 3) else begin
            timing_errors++;
            $display("ERROR %0t ns: hit done after %0d cycles, expected 3", $time, waited);
         end
      end
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   // compare each done pulse mid-cycle
   always @(negedge clk) begin : compare_done
      expect_t e;
      if (arst_n && done) begin
         assert (exp_q.size() != 0) else begin
            flag_errors++;
            $display("done pulsed at %0t ns with no request outstanding", $time);
         end
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            checks++;
            assert (err == e.err) else begin
               flag_errors++;
               $display("ERROR %0t ns: addr %h err %b, expected %b", $time, e.addr, err, e.err);
            end
            assert (cache_hit == e.hit) else begin
               flag_errors++;
               $display("ERROR %0t ns: addr %h cache_hit %b, expected %b",
                        $time, e.addr, cache_hit, e.hit);
            end
            if (e.chk_data) begin
               assert (data_out == e.data) else begin
                  data_errors++;
                  $display("ERROR %0t ns: read %h returned %h, expected %h",
                           $time, e.addr, data_out, e.data);
               end
            end
            assert (!stall) else begin
               timing_errors++;
               $display("ERROR %0t ns: stall high during done", $time);
            end
         end
      end
   end

   // hangs end here
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, a request never finished", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin : stimulus
      logic [TAG_W-1:0]   r_tag;
      logic [INDEX_W-1:0] r_idx;
      logic [1:0]         r_word;
      logic [ADDR_W-1:0]  r_addr;
      logic               r_wr;
      int                 total;
      void'($urandom(32'hcfa9));
      arst_n        = 1'b0;
      addr          = '0;
      data_in       = '0;
      rd            = 1'b0;
      wr            = 1'b0;
      checks        = 0;
      data_errors   = 0;
      flag_errors   = 0;
      timing_errors = 0;
      for (int w = 0; w < `MS_MEM_WORDS; w++) shadow_mem[w] = '0;
      for (int l = 0; l < LINES; l++) begin
         shadow_tag[l]   = '0;
         shadow_valid[l] = 1'b0;
      end
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // untouched address reads zero
      run_request(1'b1, 1'b0, 16'h0100, 16'h0000);
      // write allocates and the read hits
      run_request(1'b0, 1'b1, 16'h0208, 16'h1234);
      run_request(1'b1, 1'b0, 16'h0208, 16'h0000);
      // same index with another tag and dirty victims both ways
      run_request(1'b0, 1'b1, 16'h0410, 16'ha5a5);
      run_request(1'b1, 1'b0, 16'h0c10, 16'h0000);
      run_request(1'b1, 1'b0, 16'h0410, 16'h0000);
      run_request(1'b0, 1'b1, 16'h0c10, 16'h5a5a);
      run_request(1'b1, 1'b0, 16'h0410, 16'h0000);
      run_request(1'b1, 1'b0, 16'h0c10, 16'h0000);
      // neighbour words come back with the refilled line
      run_request(1'b0, 1'b1, 16'h1020, 16'h1111);
      run_request(1'b0, 1'b1, 16'h1022, 16'h2222);
      run_request(1'b1, 1'b0, 16'h1820, 16'h0000);
      run_request(1'b1, 1'b0, 16'h1020, 16'h0000);
      run_request(1'b1, 1'b0, 16'h1022, 16'h0000);
      run_request(1'b1, 1'b0, 16'h1026, 16'h0000);
      // odd address and double strobe leave the line unchanged
      run_request(1'b0, 1'b1, 16'h0209, 16'hdead);
      run_request(1'b1, 1'b1, 16'h0208, 16'hbeef);
      run_request(1'b1, 1'b0, 16'h0208, 16'h0000);
      run_request(1'b1, 1'b0, 16'h0101, 16'h0000);

      // four tags over two indices so lines keep colliding
      for (int n = 0; n < NUM_RANDOM; n++) begin
         r_tag  = TAG_W'($urandom_range(3, 0));
         r_idx  = INDEX_W'(8'h10 + $urandom_range(1, 0));
         r_word = 2'($urandom_range(3, 0));
         r_addr = {r_tag, r_idx, r_word, 1'b0};
         // rare misaligned request
         if ($urandom_range(31, 0) == 0) r_addr[0] = 1'b1;
         r_wr = 1'($urandom_range(1, 0));
         run_request(!r_wr, r_wr, r_addr, DATA_W'($urandom));
      end

      repeat (4) @(posedge clk);
      total = data_errors + flag_errors + timing_errors;
      $display("checks %0d, data errors %0d, flag errors %0d, timing errors %0d",
               checks, data_errors, flag_errors, timing_errors);
      if (total == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/mem_sys_pkg.sv
rtl/cache_if.sv
rtl/mem_if.sv
rtl/cache_ctrl.sv
rtl/cache_array.sv
rtl/banked_mem.sv
rtl/mem_system.sv
bench/mem_system_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mem_system_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = RESULT: PASS
SOURCES   = $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output is shown, the status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
